/* condCheck.sv */
// combinational condition evaluation against the flags, ALU table or jump table
`timescale 1ns/1ps
`include "cpu_consts.svh"

module condCheck (
    input  cpuPkg::cond_t   cond,
    input  logic            isJumpCond,
    input  cpuPkg::flags_t  flags,
    output logic            holds
);

    logic c, s, v, z;

    assign c = flags[`FLAG_CARRY];
    assign s = flags[`FLAG_SIGN];
    assign v = flags[`FLAG_OVERFLOW];
    assign z = flags[`FLAG_ZERO];

    always_comb begin
        holds = 1'b0;
        if (isJumpCond) begin
            // jump table, codes 6 and 7 never hold
            case (cond)
                4'd0:    holds = z;
                4'd1:    holds = !z;
                4'd2:    holds = !z && (s == v);
                4'd3:    holds = (s == v);
                4'd4:    holds = (s != v);
                4'd5:    holds = z && (s != v);
                default: holds = 1'b0;
            endcase
        end else begin
            case (cond)
                4'd0:  holds = z;
                4'd1:  holds = !z;
                4'd2:  holds = !z && (s == v);
                4'd3:  holds = (s != v);
                4'd4:  holds = (s == v);
                4'd5:  holds = z || (s != v);
                4'd6:  holds = c;
                4'd7:  holds = !c;
                4'd8:  holds = s;
                4'd9:  holds = !s;
                4'd10: holds = 1'b1;
                4'd11: holds = 1'b0;
                4'd12: holds = v;
                4'd13: holds = !v;
                4'd14: holds = c && !z;
                4'd15: holds = !c || z;
            endcase
        end
    end

endmodule

/* cpuCore.sv */
// top level of the decode and execute path, takes an instruction stream and reports retires and jumps
`timescale 1ns/1ps

module cpuCore (
    input  logic             clock,
    input  logic             arstN,
    input  logic             instrValid,
    output logic             instrReady,
    input  cpuPkg::word_t    instrData,
    input  cpuPkg::regIdx_t  readAddr,
    output cpuPkg::word_t    readData,
    output cpuPkg::flags_t   flags,
    output logic             retireValid,
    output logic             jumpValid,
    output logic             jumpTaken,
    output cpuPkg::word_t    jumpTarget
);

    cpuPkg::regIdx_t readAddrA;
    cpuPkg::regIdx_t readAddrB;
    cpuPkg::word_t   readDataA;
    cpuPkg::word_t   readDataB;
    logic            writeEnable;
    cpuPkg::regIdx_t writeAddr;
    cpuPkg::word_t   writeData;

    // one word per cycle, only held off during reset
    assign instrReady = arstN;

    decodeIf decBus ();

    instructionDecoder decoderInst (
        .clock      (clock),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrData  (instrData),
        .dec        (decBus.source)
    );

    executeStage executeInst (
        .clock       (clock),
        .arstN       (arstN),
        .dec         (decBus.sink),
        .readAddrA   (readAddrA),
        .readAddrB   (readAddrB),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .flags       (flags),
        .retireValid (retireValid),
        .jumpValid   (jumpValid),
        .jumpTaken   (jumpTaken),
        .jumpTarget  (jumpTarget)
    );

    registerFile regFileInst (
        .clock       (clock),
        .arstN       (arstN),
        .readAddrA   (readAddrA),
        .readAddrB   (readAddrB),
        .debugAddr   (readAddr),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .debugData   (readData),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

endmodule

/* cpuCore_assert.sv */
// concurrent protocol checks on the cpuCore ports bound into the DUT by the testbench build
`timescale 1ns/1ps

module cpuCore_assert (
    input logic clock,
    input logic arstN,
    input logic instrValid,
    input logic instrReady,
    input logic retireValid,
    input logic jumpValid
);

    // read by the testbench at the end of the run
    int failCount = 0;

    readyLowInReset: assert property (@(posedge clock) !arstN |-> !instrReady)
        else begin
            failCount++;
            $error("instrReady is high while reset is asserted");
        end

    // decode stage then execute stage
    retireAfterAccept: assert property (@(posedge clock) disable iff (!arstN)
        instrValid && instrReady |-> ##2 retireValid)
        else begin
            failCount++;
            $error("accepted word did not retire two cycles later");
        end

    retireOnlyFromAccept: assert property (@(posedge clock) disable iff (!arstN)
        retireValid |-> $past(instrValid && instrReady, 2))
        else begin
            failCount++;
            $error("retire pulse without a word accepted two cycles earlier");
        end

    jumpWithRetire: assert property (@(posedge clock) disable iff (!arstN)
        jumpValid |-> retireValid)
        else begin
            failCount++;
            $error("jumpValid without retireValid");
        end

    quietAfterReset: assert property (@(posedge clock) $rose(arstN) |-> !retireValid && !jumpValid)
        else begin
            failCount++;
            $error("retire or jump pulse in the first cycle after reset");
        end

endmodule

bind cpuCore cpuCore_assert u_assert (
    .clock       (clock),
    .arstN       (arstN),
    .instrValid  (instrValid),
    .instrReady  (instrReady),
    .retireValid (retireValid),
    .jumpValid   (jumpValid)
);

/* cpuCore_tb.sv */
// testbench for cpuCore that checks random instruction words against a reference model at retire
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuCore_tb;

    localparam int numAlu      = 40;
    localparam int numMoves    = 20;
    localparam int numJumps    = 16;
    localparam int numNoop     = 12;
    localparam int numMix      = 60;
    localparam int totalWords  = 14 + numAlu + numMoves + 2 * numJumps + numNoop + numMix;
    localparam int limitCycles = 4 * totalWords + 6 * 40;

    // what the model expects to see when a cycle's word retires
    typedef struct packed {
        logic            valid;
        cpuPkg::regIdx_t idx;
        cpuPkg::word_t   value;
        cpuPkg::flags_t  flags;
        logic            jump;
        logic            taken;
        cpuPkg::word_t   target;
    } expect_t;

    logic            clock;
    logic            arstN;
    logic            instrValid;
    logic            instrReady;
    cpuPkg::word_t   instrData;
    cpuPkg::regIdx_t readAddr;
    cpuPkg::word_t   readData;
    cpuPkg::flags_t  flags;
    logic            retireValid;
    logic            jumpValid;
    logic            jumpTaken;
    cpuPkg::word_t   jumpTarget;

    cpuPkg::word_t   modelRegs [8];
    cpuPkg::flags_t  modelFlags;
    expect_t         pending [$];
    string           currentTest;
    int              checks;
    int              errors;
    int              testCount;
    int              startChecks;
    int              startErrors;
    int              assertFails;

    cpuCore u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        #(limitCycles * 8);
        $display("watchdog expired after %0d cycles, the run did not finish", limitCycles);
        $display("Checks failed");
        $finish;
    end

    task automatic checkValue(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s %s: expected 0x%0h, actual 0x%0h", currentTest, what, expected,
                     actual);
        end
    endtask

    function automatic logic aluHolds(input cpuPkg::cond_t cond, input cpuPkg::flags_t f);
        logic c;
        logic s;
        logic v;
        logic z;
        c = f[`FLAG_CARRY];
        s = f[`FLAG_SIGN];
        v = f[`FLAG_OVERFLOW];
        z = f[`FLAG_ZERO];
        // EQ NE GT LT GE LE CS CC MI PL AL NV VS VC HI LS
        case (cond)
            4'd0:    return z;
            4'd1:    return !z;
            4'd2:    return !z && s == v;
            4'd3:    return s != v;
            4'd4:    return s == v;
            4'd5:    return z || s != v;
            4'd6:    return c;
            4'd7:    return !c;
            4'd8:    return s;
            4'd9:    return !s;
            4'd10:   return 1'b1;
            4'd11:   return 1'b0;
            4'd12:   return v;
            4'd13:   return !v;
            4'd14:   return c && !z;
            default: return !c || z;
        endcase
    endfunction

    function automatic logic jumpHolds(input logic [2:0] cond, input cpuPkg::flags_t f);
        logic sv;
        logic z;
        sv = f[`FLAG_SIGN] != f[`FLAG_OVERFLOW];
        z  = f[`FLAG_ZERO];
        // EQ NE GT GE LT LE where the jump LE needs zero and a sign mismatch
        case (cond)
            3'd0:    return z;
            3'd1:    return !z;
            3'd2:    return !z && !sv;
            3'd3:    return !sv;
            3'd4:    return sv;
            3'd5:    return z && sv;
            default: return 1'b0;
        endcase
    endfunction

    // reference model applying one word in program order at acceptance
    task automatic applyWord(input cpuPkg::word_t w, output expect_t e);
        cpuPkg::word_t av;
        cpuPkg::word_t bv;
        cpuPkg::word_t res;
        logic [16:0]   sum;
        logic [4:0]    wide;
        logic          c;
        logic          v;
        av      = modelRegs[w[5:3]];
        bv      = modelRegs[w[2:0]];
        wide    = w[13:9];
        e       = '0;
        e.valid = 1'b1;
        e.idx   = w[5:3];
        if (w[15] || (!w[14] && w[13:11] == 3'b000)) begin
            // core control and load/store leave the state alone
        end else if (w[14]) begin
            c   = 1'b0;
            v   = 1'b0;
            res = bv;
            case (w[13:10])
                `OP_ADD: begin
                    sum = {1'b0, av} + {1'b0, bv};
                    res = sum[15:0];
                    c   = sum[16];
                    v   = av[15] == bv[15] && res[15] != av[15];
                end
                `OP_SUB, `OP_CMP: begin
                    res = av - bv;
                    c   = av < bv;
                    v   = av[15] != bv[15] && res[15] != av[15];
                end
                `OP_AND: res = av & bv;
                `OP_OR:  res = av | bv;
                `OP_XOR: res = av ^ bv;
                `OP_NOT: res = ~av;
                `OP_SHL: begin
                    res = av << 1;
                    c   = av[15];
                end
                `OP_SHR: begin
                    res = av >> 1;
                    c   = av[0];
                end
                default: res = bv;
            endcase
            if (aluHolds(w[9:6], modelFlags)) begin
                modelFlags                 = '0;
                modelFlags[`FLAG_CARRY]    = c;
                modelFlags[`FLAG_SIGN]     = res[15];
                modelFlags[`FLAG_OVERFLOW] = v;
                modelFlags[`FLAG_ZERO]     = res == 16'h0000;
                if (w[13:10] != `OP_CMP) begin
                    modelRegs[w[5:3]] = res;
                end
            end
        end else if (w[13:10] == `MOVI_CODE) begin
            modelRegs[w[5:3]] = bv;
        end else if (wide >= 5'd6 && wide < 5'd12) begin
            e.idx = 3'(wide - `WIDE_MOVHI);
            modelRegs[e.idx] = {w[7:0], modelRegs[e.idx][7:0]};
        end else if (wide >= 5'd12 && wide < 5'd18) begin
            e.idx = 3'(wide - `WIDE_MOVLI);
            modelRegs[e.idx] = {modelRegs[e.idx][15:8], w[7:0]};
        end else if (wide >= 5'd18 && wide < 5'd24) begin
            e.idx = 3'(wide - `WIDE_MOVF);
            modelRegs[e.idx] = {12'h000, modelFlags};
        end else if (wide >= 5'd24 && wide < 5'd30) begin
            e.jump   = 1'b1;
            e.taken  = jumpHolds(3'(wide - `WIDE_JUMP), modelFlags);
            e.target = av;
        end
        e.value = modelRegs[e.idx];
        e.flags = modelFlags;
    endtask

    task automatic checkRetire(input expect_t due);
        checkValue("retireValid", 16'(due.valid), 16'(retireValid));
        checkValue("jumpValid", 16'(due.jump), 16'(jumpValid));
        if (due.valid) begin
            checkValue($sformatf("r%0d", due.idx), due.value, readData);
            checkValue("flags", 16'(due.flags), 16'(flags));
        end
        if (due.jump) begin
            checkValue("jumpTaken", 16'(due.taken), 16'(jumpTaken));
            checkValue("jumpTarget", due.target, jumpTarget);
        end
    endtask

    // checks the word from two cycles back and drives the next one on a falling edge
    task automatic sendCycle(input logic valid, input cpuPkg::word_t w);
        expect_t e;
        @(negedge clock);
        checkValue("instrReady", 16'd1, 16'(instrReady));
        if (pending.size() == 2) begin
            checkRetire(pending.pop_front());
        end
        if (pending.size() > 0) begin
            readAddr = pending[$].idx;
        end
        e = '0;
        if (valid) begin
            applyWord(w, e);
        end
        instrValid = valid;
        instrData  = valid ? w : cpuPkg::word_t'($urandom);
        pending.push_back(e);
    endtask

    // occasional idle cycle before the word
    task automatic sendWord(input cpuPkg::word_t w);
        if ($urandom % 4 == 0) begin
            sendCycle(1'b0, '0);
        end
        sendCycle(1'b1, w);
    endtask

    task automatic sweepRegisters();
        pending.delete();
        for (int i = 0; i < 9; i++) begin
            @(negedge clock);
            if (i > 0) begin
                checkValue($sformatf("final r%0d", i - 1), modelRegs[i - 1], readData);
            end
            instrValid = 1'b0;
            readAddr   = 3'(i);
        end
        checkValue("final flags", 16'(modelFlags), 16'(flags));
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        startChecks = checks;
        startErrors = errors;
    endtask

    task automatic closeTest();
        sendCycle(1'b0, '0);
        sendCycle(1'b0, '0);
        sweepRegisters();
        testCount++;
        $display("test %s: %0d checks, %0d errors", currentTest, checks - startChecks,
                 errors - startErrors);
    endtask

    function automatic cpuPkg::word_t aluWord(input logic [3:0] op, input logic [3:0] cond,
                                              input logic [2:0] a, input logic [2:0] b);
        return {2'b01, op, cond, a, b};
    endfunction

    function automatic cpuPkg::word_t immWord(input logic [4:0] base, input logic [2:0] r,
                                              input logic [7:0] imm);
        return {2'b00, 5'(base + r), 1'b0, imm};
    endfunction

    initial begin
        int kind;
        void'($urandom(41485));
        arstN      = 1'b0;
        instrValid = 1'b0;
        instrData  = '0;
        readAddr   = '0;
        modelFlags = '0;
        checks     = 0;
        errors     = 0;
        testCount  = 0;
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end
        startTest("reset");
        repeat (3) @(posedge clock);
        @(negedge clock);
        checkValue("instrReady in reset", 16'd0, 16'(instrReady));
        arstN = 1'b1;

        repeat (4) sendCycle(1'b0, '0);
        closeTest();

        startTest("alu");
        for (int r = 0; r < 6; r++) begin
            sendWord(immWord(`WIDE_MOVHI, 3'(r), 8'($urandom)));
            sendWord(immWord(`WIDE_MOVLI, 3'(r), 8'($urandom)));
        end
        // r6 and r7 get MOVB under AL since no immediate move reaches them
        sendWord(aluWord(4'd9, 4'd10, 3'd6, 3'($urandom % 6)));
        sendWord(aluWord(4'd9, 4'd10, 3'd7, 3'($urandom % 6)));
        repeat (numAlu) sendWord(aluWord(4'($urandom), 4'($urandom), 3'($urandom), 3'($urandom)));
        closeTest();

        startTest("moves");
        repeat (numMoves) begin
            kind = $urandom % 4;
            case (kind)
                0: sendWord({2'b00, `MOVI_CODE, 4'b0000, 3'($urandom % 6), 3'($urandom)});
                1: sendWord(immWord(`WIDE_MOVHI, 3'($urandom % 6), 8'($urandom)));
                2: sendWord(immWord(`WIDE_MOVLI, 3'($urandom % 6), 8'($urandom)));
                default: sendWord(immWord(`WIDE_MOVF, 3'($urandom % 6), 8'($urandom)));
            endcase
        end
        closeTest();

        startTest("jumps");
        repeat (numJumps) begin
            sendWord(aluWord(`OP_CMP, 4'd10, 3'($urandom), 3'($urandom)));
            sendWord({2'b00, 5'(`WIDE_JUMP + $urandom % 6), 3'b000, 3'($urandom), 3'b000});
        end
        closeTest();

        startTest("noop");
        repeat (numNoop) begin
            kind = $urandom % 3;
            case (kind)
                0: sendWord({1'b1, 15'($urandom)});
                1: sendWord({5'b00000, 11'($urandom)});
                default: sendWord({2'b00, 4'b1111, 10'($urandom)});
            endcase
        end
        closeTest();

        startTest("mix");
        repeat (numMix) sendCycle(1'b1, cpuPkg::word_t'($urandom));
        closeTest();

        assertFails = u_dut.u_assert.failCount;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", testCount, checks,
                 errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* cpuPkg.sv */
// shared data types of the CPU core, referenced by scoped name from the RTL and testbench
package cpuPkg;

    // data and instruction word
    typedef logic [15:0] word_t;

    // register number, eight registers
    typedef logic [2:0] regIdx_t;

    // ALU selector, opcode in the upper four bits and bit 0 kept zero
    typedef logic [4:0] aluSel_t;

    // condition code, ALU table or jump table
    typedef logic [3:0] cond_t;

    // carry, sign, overflow, zero
    typedef logic [3:0] flags_t;

    typedef enum logic [3:0] {
        instrCore,
        instrAlu,
        instrLoadStore,
        instrMovi,
        instrMovli,
        instrMovhi,
        instrMovf,
        instrJump,
        instrNone
    } instrType_t;

endpackage

/* cpu_consts.svh */
// instruction field positions, opcode values and flag indices, included by the decode and execute RTL
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// flag bit indices
`define FLAG_CARRY    0
`define FLAG_SIGN     1
`define FLAG_OVERFLOW 2
`define FLAG_ZERO     3

// instruction word fields
`define CORE_BIT 15
`define ALU_BIT  14
`define OP_HI    13
`define OP_LO    10
`define COND_HI  9
`define COND_LO  6
`define REGA_HI  5
`define REGA_LO  3
`define REGB_HI  2
`define REGB_LO  0
`define WIDE_HI  13
`define WIDE_LO  9
`define IMM_HI   7
`define IMM_LO   0

// ALU opcodes, 9 to 15 all decode as MOVB
`define OP_ADD 4'd0
`define OP_SUB 4'd1
`define OP_AND 4'd2
`define OP_OR  4'd3
`define OP_XOR 4'd4
`define OP_NOT 4'd5
`define OP_SHL 4'd6
`define OP_SHR 4'd7
`define OP_CMP 4'd8

// movi code in the opcode field
`define MOVI_CODE 4'd2

// first code of each wide opcode range, six codes per range
`define WIDE_MOVHI 5'd6
`define WIDE_MOVLI 5'd12
`define WIDE_MOVF  5'd18
`define WIDE_JUMP  5'd24
`define WIDE_SPAN  5'd6

`endif

/* decodeIf.sv */
// decoded instruction fields passed from the decoder to the execute stage, one item per cycle
`timescale 1ns/1ps

interface decodeIf;

    logic                valid;
    cpuPkg::instrType_t  instrType;
    cpuPkg::aluSel_t     sel;
    cpuPkg::regIdx_t     firstReg;
    cpuPkg::regIdx_t     secondReg;
    cpuPkg::cond_t       cond;
    // selects the jump condition table in condCheck
    logic                isJumpCond;
    logic [7:0]          imm;

    modport source (
        output valid, instrType, sel, firstReg, secondReg, cond, isJumpCond, imm
    );

    modport sink (
        input valid, instrType, sel, firstReg, secondReg, cond, isJumpCond, imm
    );

endinterface

/* executeStage.sv */
// execute stage, reads registers, checks the condition, runs ALU or move, writes back and retires
`timescale 1ns/1ps
`include "cpu_consts.svh"

module executeStage (
    input  logic             clock,
    input  logic             arstN,
    decodeIf.sink            dec,
    output cpuPkg::regIdx_t  readAddrA,
    output cpuPkg::regIdx_t  readAddrB,
    input  cpuPkg::word_t    readDataA,
    input  cpuPkg::word_t    readDataB,
    output logic             writeEnable,
    output cpuPkg::regIdx_t  writeAddr,
    output cpuPkg::word_t    writeData,
    output cpuPkg::flags_t   flags,
    output logic             retireValid,
    output logic             jumpValid,
    output logic             jumpTaken,
    output cpuPkg::word_t    jumpTarget
);

    cpuPkg::flags_t flagReg;
    cpuPkg::flags_t aluFlags;
    cpuPkg::word_t  aluRes;
    logic [3:0]     op;
    logic [16:0]    sum;
    logic [16:0]    diff;
    logic           carry;
    logic           ovf;
    logic           holds;
    logic           isAlu;

    assign readAddrA = dec.firstReg;
    assign readAddrB = dec.secondReg;
    assign writeAddr = dec.firstReg;
    assign op        = dec.sel[4:1];
    assign isAlu     = dec.valid && dec.instrType == cpuPkg::instrAlu;
    assign flags     = flagReg;

    // always sees the flags left by the previous instruction
    condCheck condCheckInst (
        .cond       (dec.cond),
        .isJumpCond (dec.isJumpCond),
        .flags      (flagReg),
        .holds      (holds)
    );

    assign sum  = {1'b0, readDataA} + {1'b0, readDataB};
    assign diff = {1'b0, readDataA} - {1'b0, readDataB};

    always_comb begin
        aluRes = readDataB;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (op)
            `OP_ADD: begin
                aluRes = sum[15:0];
                carry  = sum[16];
                ovf    = (readDataA[15] == readDataB[15]) && (sum[15] != readDataA[15]);
            end
            // carry holds the borrow
            `OP_SUB, `OP_CMP: begin
                aluRes = diff[15:0];
                carry  = diff[16];
                ovf    = (readDataA[15] != readDataB[15]) && (diff[15] != readDataA[15]);
            end
            `OP_AND: aluRes = readDataA & readDataB;
            `OP_OR:  aluRes = readDataA | readDataB;
            `OP_XOR: aluRes = readDataA ^ readDataB;
            `OP_NOT: aluRes = ~readDataA;
            `OP_SHL: begin
                aluRes = {readDataA[14:0], 1'b0};
                carry  = readDataA[15];
            end
            `OP_SHR: begin
                aluRes = {1'b0, readDataA[15:1]};
                carry  = readDataA[0];
            end
            // MOVB
            default: aluRes = readDataB;
        endcase
        aluFlags                 = '0;
        aluFlags[`FLAG_CARRY]    = carry;
        aluFlags[`FLAG_OVERFLOW] = ovf;
        aluFlags[`FLAG_SIGN]     = aluRes[15];
        aluFlags[`FLAG_ZERO]     = (aluRes == '0);
    end

    // writeback mux, jumps and no-op types write nothing
    always_comb begin
        writeEnable = 1'b0;
        writeData   = aluRes;
        if (dec.valid) begin
            case (dec.instrType)
                cpuPkg::instrAlu:   writeEnable = holds && op != `OP_CMP;
                cpuPkg::instrMovi: begin
                    writeEnable = 1'b1;
                    writeData   = readDataB;
                end
                cpuPkg::instrMovhi: begin
                    writeEnable = 1'b1;
                    writeData   = {dec.imm, readDataA[7:0]};
                end
                cpuPkg::instrMovli: begin
                    writeEnable = 1'b1;
                    writeData   = {readDataA[15:8], dec.imm};
                end
                cpuPkg::instrMovf: begin
                    writeEnable = 1'b1;
                    writeData   = {12'b0, flagReg};
                end
                default: writeEnable = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            flagReg     <= '0;
            retireValid <= 1'b0;
            jumpValid   <= 1'b0;
            jumpTaken   <= 1'b0;
        end else begin
            if (isAlu && holds) begin
                flagReg <= aluFlags;
            end
            retireValid <= dec.valid;
            jumpValid   <= dec.valid && dec.instrType == cpuPkg::instrJump;
            jumpTaken   <= dec.valid && dec.instrType == cpuPkg::instrJump && holds;
        end
    end

    // target is register A, reported whether taken or not
    always_ff @(posedge clock) begin
        if (dec.valid) begin
            jumpTarget <= readDataA;
        end
    end

endmodule

/* instructionDecoder.sv */
// registered decoder, turns each accepted instruction word into fields on decodeIf one cycle later
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instructionDecoder (
    input  logic           clock,
    input  logic           arstN,
    input  logic           instrValid,
    input  cpuPkg::word_t  instrData,
    decodeIf.source        dec
);

    cpuPkg::instrType_t nextType;
    cpuPkg::regIdx_t    nextFirst;
    cpuPkg::cond_t      nextCond;
    logic               nextIsJump;
    logic [4:0]         wide;

    assign wide = instrData[`WIDE_HI:`WIDE_LO];

    // priority order: core, ALU, load/store, movi, then the wide ranges
    always_comb begin
        nextType   = cpuPkg::instrNone;
        nextFirst  = instrData[`REGA_HI:`REGA_LO];
        nextCond   = instrData[`COND_HI:`COND_LO];
        nextIsJump = 1'b0;
        if (instrData[`CORE_BIT]) begin
            nextType = cpuPkg::instrCore;
        end else if (instrData[`ALU_BIT]) begin
            nextType = cpuPkg::instrAlu;
        end else if (instrData[`OP_HI -: 3] == 3'b000) begin
            nextType = cpuPkg::instrLoadStore;
        end else if (instrData[`OP_HI:`OP_LO] == `MOVI_CODE) begin
            nextType = cpuPkg::instrMovi;
        end else if (wide >= `WIDE_MOVHI && wide < `WIDE_MOVHI + `WIDE_SPAN) begin
            nextType  = cpuPkg::instrMovhi;
            nextFirst = cpuPkg::regIdx_t'(wide - `WIDE_MOVHI);
        end else if (wide >= `WIDE_MOVLI && wide < `WIDE_MOVLI + `WIDE_SPAN) begin
            nextType  = cpuPkg::instrMovli;
            nextFirst = cpuPkg::regIdx_t'(wide - `WIDE_MOVLI);
        end else if (wide >= `WIDE_MOVF && wide < `WIDE_MOVF + `WIDE_SPAN) begin
            nextType  = cpuPkg::instrMovf;
            nextFirst = cpuPkg::regIdx_t'(wide - `WIDE_MOVF);
        end else if (wide >= `WIDE_JUMP && wide < `WIDE_JUMP + `WIDE_SPAN) begin
            // target register stays in field A
            nextType   = cpuPkg::instrJump;
            nextCond   = cpuPkg::cond_t'(wide - `WIDE_JUMP);
            nextIsJump = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            dec.valid     <= 1'b0;
            dec.instrType <= cpuPkg::instrNone;
        end else begin
            dec.valid <= instrValid;
            if (instrValid) begin
                dec.instrType <= nextType;
            end
        end
    end

    // payload fields only move on an accepted word
    always_ff @(posedge clock) begin
        if (instrValid) begin
            dec.sel        <= {instrData[`OP_HI:`OP_LO], 1'b0};
            dec.firstReg   <= nextFirst;
            dec.secondReg  <= instrData[`REGB_HI:`REGB_LO];
            dec.cond       <= nextCond;
            dec.isJumpCond <= nextIsJump;
            dec.imm        <= instrData[`IMM_HI:`IMM_LO];
        end
    end

endmodule

/* list.f */
+incdir+.
cpuPkg.sv
decodeIf.sv
instructionDecoder.sv
condCheck.sv
registerFile.sv
executeStage.sv
cpuCore.sv
cpuCore_assert.sv
cpuCore_tb.sv

/* registerFile.sv */
// eight 16-bit registers, two combinational read ports, a debug read port and one write port
`timescale 1ns/1ps

module registerFile (
    input  logic             clock,
    input  logic             arstN,
    input  cpuPkg::regIdx_t  readAddrA,
    input  cpuPkg::regIdx_t  readAddrB,
    input  cpuPkg::regIdx_t  debugAddr,
    output cpuPkg::word_t    readDataA,
    output cpuPkg::word_t    readDataB,
    output cpuPkg::word_t    debugData,
    input  logic             writeEnable,
    input  cpuPkg::regIdx_t  writeAddr,
    input  cpuPkg::word_t    writeData
);

    cpuPkg::word_t regs [8];

    // architectural state, cleared so software starts from zero
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];
    // readback for the top level
    assign debugData = regs[debugAddr];

endmodule
